/* hdl/bus_pkg.sv */
// command bus cycle struct, block position, register addresses and command codes
package bus_pkg;

  // one cycle on the write-only command bus
  typedef struct packed {
    logic [15:0] addr;  // high byte selects the block, low byte the register
    logic [31:0] data;
    logic        cs;
    logic        wr;
  } cmd_bus_t;

  // high address byte owned by the collector
  localparam logic [7:0] collector_position = 8'd242;

  // low address byte of each register
  localparam logic [7:0] addr_new_unit      = 8'd4;  // append a unit position
  localparam logic [7:0] addr_local_command = 8'd5;  // scan control

  // decoded from the low data byte of a command write
  typedef enum logic [7:0] {
    cmd_none  = 8'd0,
    cmd_start = 8'd1,
    cmd_stop  = 8'd2,
    cmd_reset = 8'd5
  } cmd_t;

endpackage

/* hdl/sample_pkg.sv */
// unit table limits, sample and record types, FIFO depth and thresholds
package sample_pkg;

  localparam int max_units = 8;

  typedef logic [$clog2(max_units)-1:0] slot_idx_t;
  typedef logic [7:0]                   unit_pos_t;
  typedef unit_pos_t [max_units-1:0]    unit_table_t;

  localparam unit_pos_t no_unit = 8'd255;  // empty table entry

  typedef logic [31:0] sample_word_t;  // raw word from a unit

  localparam int rec_value_w = 13;  // sample bits kept in a record

  // one FIFO entry, 16 bits
  typedef struct packed {
    slot_idx_t              slot;
    logic [rec_value_w-1:0] value;
  } sample_rec_t;

  localparam int fifo_depth  = 16;
  localparam int fifo_almost = 2;  // free or stored entries below this raise the flags
  localparam int fifo_ptr_w  = $clog2(fifo_depth);
  localparam int fifo_cnt_w  = $clog2(fifo_depth + 1);

endpackage

/* hdl/cmd_regs.sv */
// cmd_regs: bus write decode into the unit table, unit count and pending command
`timescale 1ns/100ps

module cmd_regs (
  input  logic                    clk,
  input  logic                    rst,
  input  bus_pkg::cmd_bus_t       bus,
  input  logic                    consume,
  input  logic                    clear_all,
  output sample_pkg::unit_table_t unit_table,
  output logic [3:0]              num_units,
  output bus_pkg::cmd_t           pending
);

  import bus_pkg::*;
  import sample_pkg::*;

  logic wr_hit;
  logic new_unit_wr;
  logic cmd_wr;
  logic table_full;

  // every qualifying cycle counts as one write
  assign wr_hit      = bus.cs & bus.wr & (bus.addr[15:8] == collector_position);
  assign new_unit_wr = wr_hit & (bus.addr[7:0] == addr_new_unit);
  assign cmd_wr      = wr_hit & (bus.addr[7:0] == addr_local_command);
  assign table_full  = (num_units == 4'(max_units));

  // unit table, filled in write order
  always_ff @(posedge clk) begin
    if (rst || clear_all) begin
      unit_table <= {max_units{no_unit}};
      num_units  <= '0;
    end else if (new_unit_wr && !table_full) begin
      unit_table[slot_idx_t'(num_units)] <= unit_pos_t'(bus.data[7:0]);
      num_units                          <= num_units + 4'd1;
    end
  end

  // last command written, held until the sequencer takes it
  always_ff @(posedge clk) begin
    if (rst) begin
      pending <= cmd_none;
    end else if (consume) begin
      pending <= cmd_none;  // wins over a write in the same cycle
    end else if (cmd_wr) begin
      pending <= cmd_t'(bus.data[7:0]);  // only the low byte is decoded
    end
  end

endmodule

/* hdl/scan_sequencer.sv */
// scan_sequencer: one-hot scan FSM, slot counter, sample pulse and capture strobes
`timescale 1ns/100ps

module scan_sequencer (
  input  logic                  clk,
  input  logic                  rst,
  input  bus_pkg::cmd_t         pending,
  input  logic [3:0]            num_units,
  output logic                  consume,
  output logic                  clear_all,
  output logic                  output_sample,
  output logic                  capture,
  output logic                  judge,
  output sample_pkg::slot_idx_t cur_slot
);

  import bus_pkg::*;

  typedef enum logic [4:0] {
    idle       = 5'b00001,
    fetch      = 5'b00010,  // unit told to present data
    fetch_wait = 5'b00100,  // unit settling
    store      = 5'b01000,  // sample_data taken at the end of this state
    increment  = 5'b10000   // change check and slot step
  } state_t;

  state_t state;
  state_t next_state;
  logic   start_hit;
  logic   halt_hit;
  logic   last_slot;

  // start with an empty table is swallowed in idle
  assign start_hit = (state == idle) && (pending == cmd_start) && (num_units != 4'd0);
  // stop and reset only take effect at a slot boundary
  assign halt_hit  = (state == increment) && ((pending == cmd_stop) || (pending == cmd_reset));

  // idle drains any command, unknown codes included
  assign consume   = ((state == idle) && (pending != cmd_none)) || halt_hit;
  assign last_slot = ({1'b0, cur_slot} == (num_units - 4'd1));

  always_comb begin
    next_state = state;
    case (state)
      idle: begin
        if (start_hit) begin
          next_state = fetch;
        end
      end
      fetch:      next_state = fetch_wait;
      fetch_wait: next_state = store;
      store:      next_state = increment;
      increment:  next_state = halt_hit ? idle : fetch;
      default:    next_state = idle;  // recover from a broken one-hot code
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state     <= idle;
      clear_all <= 1'b0;
      cur_slot  <= '0;
    end else begin
      state     <= next_state;
      clear_all <= consume && (pending == cmd_reset);  // one cycle after the reset command
      if (clear_all || start_hit) begin
        cur_slot <= '0;
      end else if (state == increment) begin
        cur_slot <= last_slot ? '0 : cur_slot + 3'd1;  // round robin over registered units
      end
    end
  end

  assign output_sample = (state == fetch) || (state == fetch_wait);
  assign capture       = (state == store);
  assign judge         = (state == increment);

endmodule

/* hdl/change_filter.sv */
// change_filter: per-slot capture and history registers, FIFO write on changed samples
`timescale 1ns/100ps

module change_filter (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     clear_all,
  input  logic                     capture,
  input  logic                     judge,
  input  sample_pkg::slot_idx_t    cur_slot,
  input  sample_pkg::sample_word_t sample_data,
  input  logic                     fifo_full,
  output logic                     fifo_wr,
  output sample_pkg::sample_rec_t  fifo_din
);

  import sample_pkg::*;

  sample_word_t captured [max_units];  // latest word per slot
  sample_word_t history  [max_units];  // word last sent to the FIFO
  logic         changed;

  always_ff @(posedge clk) begin
    if (capture) begin
      captured[cur_slot] <= sample_data;
    end
  end

  // whole word compared, only the low bits are stored
  assign changed = (captured[cur_slot] != history[cur_slot]);

  // a change meeting a full FIFO is lost, history stays put
  assign fifo_wr = judge & changed & ~fifo_full;

  assign fifo_din = '{
    slot:  cur_slot,
    value: captured[cur_slot][rec_value_w-1:0]
  };

  always_ff @(posedge clk) begin
    if (rst || clear_all) begin
      for (int i = 0; i < max_units; i++) begin
        history[i] <= '0;
      end
    end else if (fifo_wr) begin
      history[cur_slot] <= captured[cur_slot];
    end
  end

endmodule

/* hdl/sample_fifo.sv */
// sample_fifo: synchronous circular-buffer FIFO over a generic payload type
`timescale 1ns/100ps

module sample_fifo #(
  parameter type payload_t = logic [15:0]
) (
  input  logic     clk,
  input  logic     rst,
  input  logic     wr_en,
  input  logic     rd_en,
  input  payload_t din,
  output payload_t dout,
  output logic     empty,
  output logic     almost_empty,
  output logic     full,
  output logic     almost_full
);

  import sample_pkg::*;

  payload_t              mem [fifo_depth];
  logic [fifo_ptr_w-1:0] wr_ptr;
  logic [fifo_ptr_w-1:0] rd_ptr;
  logic [fifo_cnt_w-1:0] count;  // entries stored
  logic                  do_wr;
  logic                  do_rd;

  assign do_wr = wr_en & ~full;   // write into a full buffer is dropped
  assign do_rd = rd_en & ~empty;  // read of an empty buffer is ignored

  always_ff @(posedge clk) begin
    if (do_wr) begin
      mem[wr_ptr] <= din;
    end
  end

  // pointers wrap on their own, depth is a power of two
  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_wr) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (do_rd) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({do_wr, do_rd})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;  // idle, or read and write together
      endcase
    end
  end

  assign dout         = mem[rd_ptr];  // head entry, no read latency
  assign empty        = (count == '0);
  assign full         = (count == fifo_cnt_w'(fifo_depth));
  assign almost_empty = (count < fifo_cnt_w'(fifo_almost));
  assign almost_full  = ((fifo_cnt_w'(fifo_depth) - count) < fifo_cnt_w'(fifo_almost));

endmodule

/* hdl/sample_collector.sv */
// sample_collector: top level tying command registers, scan FSM, change filter and FIFO
`timescale 1ns/100ps

module sample_collector (
  input  logic                     clk,
  input  logic                     rst,
  input  bus_pkg::cmd_bus_t        bus,
  input  sample_pkg::sample_word_t sample_data,
  input  logic                     sample_fifo_rd_en,
  output logic                     output_sample,
  output sample_pkg::unit_pos_t    channel_select,
  output sample_pkg::sample_rec_t  sample_data_out,
  output logic                     sample_fifo_empty,
  output logic                     sample_fifo_almost_empty,
  output logic                     sample_fifo_full,
  output logic                     sample_fifo_almost_full
);

  import bus_pkg::*;
  import sample_pkg::*;

  unit_table_t unit_table;
  logic [3:0]  num_units;
  cmd_t        pending;
  logic        consume;
  logic        clear_all;
  logic        capture;
  logic        judge;
  slot_idx_t   cur_slot;
  logic        fifo_wr;
  sample_rec_t fifo_din;

  cmd_regs u_cmd_regs (
    .clk        (clk),
    .rst        (rst),
    .bus        (bus),
    .consume    (consume),
    .clear_all  (clear_all),
    .unit_table (unit_table),
    .num_units  (num_units),
    .pending    (pending)
  );

  scan_sequencer u_scan_sequencer (
    .clk           (clk),
    .rst           (rst),
    .pending       (pending),
    .num_units     (num_units),
    .consume       (consume),
    .clear_all     (clear_all),
    .output_sample (output_sample),
    .capture       (capture),
    .judge         (judge),
    .cur_slot      (cur_slot)
  );

  assign channel_select = unit_table[cur_slot];  // position of the unit being scanned

  change_filter u_change_filter (
    .clk         (clk),
    .rst         (rst),
    .clear_all   (clear_all),
    .capture     (capture),
    .judge       (judge),
    .cur_slot    (cur_slot),
    .sample_data (sample_data),
    .fifo_full   (sample_fifo_full),
    .fifo_wr     (fifo_wr),
    .fifo_din    (fifo_din)
  );

  sample_fifo #(
    .payload_t (sample_rec_t)
  ) u_sample_fifo (
    .clk          (clk),
    .rst          (rst),
    .wr_en        (fifo_wr),
    .rd_en        (sample_fifo_rd_en),
    .din          (fifo_din),
    .dout         (sample_data_out),
    .empty        (sample_fifo_empty),
    .almost_empty (sample_fifo_almost_empty),
    .full         (sample_fifo_full),
    .almost_full  (sample_fifo_almost_full)
  );

endmodule

/* tests/sample_collector_properties.sv */
// sample_collector_properties: pulse and strobe assertions for the scan FSM, with its bind
`timescale 1ns/100ps

module sample_collector_properties (
  input logic       clk,
  input logic       rst,
  input logic [4:0] state,
  input logic       output_sample,
  input logic       capture,
  input logic       judge
);

  localparam logic [4:0] idle_code = 5'b00001;  // one-hot idle

  // pulse that just ended was high for exactly two cycles
  pulse_two_cycles: assert property (@(posedge clk) disable iff (rst)
    $fell(output_sample) |-> $past(output_sample, 2) && !$past(output_sample, 3))
    else $error("output_sample pulse is not two cycles long");

  capture_after_pulse: assert property (@(posedge clk) disable iff (rst)
    $fell(output_sample) |-> capture)
    else $error("capture missing after output_sample falls");

  judge_after_capture: assert property (@(posedge clk) disable iff (rst)
    capture |=> judge)
    else $error("judge does not follow capture");

  quiet_in_idle: assert property (@(posedge clk) disable iff (rst)
    (state == idle_code) |-> !output_sample && !judge)
    else $error("output_sample or judge high in idle");

endmodule

bind scan_sequencer sample_collector_properties u_props (
  .clk           (clk),
  .rst           (rst),
  .state         (state),
  .output_sample (output_sample),
  .capture       (capture),
  .judge         (judge)
);

/* tests/tb_sample_collector.sv */
// tb_sample_collector: clock, reset, LFSR stimulus, reference model, checks and timeout
`timescale 1ns/100ps

module tb_sample_collector;

  import bus_pkg::*;
  import sample_pkg::*;

  // all phases together stay far below this, even with slow random draining
  localparam int max_cycles = 20000;

  logic         clk;
  logic         rst;
  cmd_bus_t     bus;
  sample_word_t sample_data;
  logic         sample_fifo_rd_en;
  logic         output_sample;
  unit_pos_t    channel_select;
  sample_rec_t  sample_data_out;
  logic         sample_fifo_empty;
  logic         sample_fifo_almost_empty;
  logic         sample_fifo_full;
  logic         sample_fifo_almost_full;

  logic [15:0]  lfsr_state;
  cmd_bus_t     bus_next;    // bus value applied at the next tick
  logic         reads_on;    // random read strobes while set
  logic         sample_due;  // a unit is presenting, pick its next word
  int           cycles;
  int           rises;       // output_sample pulses seen so far

  unit_pos_t    model_table [max_units];
  int           model_units;
  int           model_slot;
  sample_word_t model_hist [max_units];
  sample_rec_t  model_q [$];
  sample_word_t cap_word;
  int           cap_slot;
  logic         judge_due;
  logic         prev_sample;

  sample_collector u_dut (
    .clk                      (clk),
    .rst                      (rst),
    .bus                      (bus),
    .sample_data              (sample_data),
    .sample_fifo_rd_en        (sample_fifo_rd_en),
    .output_sample            (output_sample),
    .channel_select           (channel_select),
    .sample_data_out          (sample_data_out),
    .sample_fifo_empty        (sample_fifo_empty),
    .sample_fifo_almost_empty (sample_fifo_almost_empty),
    .sample_fifo_full         (sample_fifo_full),
    .sample_fifo_almost_full  (sample_fifo_almost_full)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // 16-bit Fibonacci LFSR, taps 16 14 13 11
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      v = {v[30:0], lfsr_state[0]};
    end
    return v;
  endfunction

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("Something failed");
    $fatal(1, "run aborted");
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      $display("[ERROR] %s: got 0x%0h, expected 0x%0h", name, got, exp);
      abort_run("value mismatch, stopping");
    end
  endtask

  initial begin : cycle_limit
    cycles = 0;
    while (cycles < max_cycles) begin
      @(posedge clk);
      cycles++;
    end
    abort_run("timeout: test sequence did not finish within the cycle limit");
  end

  // one clock step, inputs change 1 ns after the edge
  task automatic tick();
    logic [31:0] r;
    @(posedge clk);
    #1;
    bus = bus_next;
    if (reads_on) begin
      r = rand_bits(1);
      sample_fifo_rd_en = r[0];
    end else begin
      sample_fifo_rd_en = 1'b0;
    end
    if (sample_due) begin
      r = rand_bits(1);
      if (r[0]) begin
        sample_data = rand_bits(32);  // fresh word, otherwise repeat the old one
      end
      sample_due = 1'b0;
    end
  endtask

  task automatic write_reg(input logic [15:0] addr, input logic [31:0] data);
    bus_next = '{addr: addr, data: data, cs: 1'b1, wr: 1'b1};
    tick();
    bus_next = '0;
    tick();
  endtask

  task automatic add_unit(input unit_pos_t pos);
    write_reg({collector_position, addr_new_unit}, {24'd0, pos});
    if (model_units < max_units) begin  // full table drops the write
      model_table[model_units] = pos;
      model_units++;
    end
  endtask

  task automatic send_cmd(input cmd_t c);
    write_reg({collector_position, addr_local_command}, {24'd0, 8'(c)});
    if (c == cmd_start) begin
      model_slot = 0;
    end
  endtask

  task automatic clear_model();
    for (int i = 0; i < max_units; i++) begin
      model_table[i] = no_unit;
      model_hist[i]  = '0;
    end
    model_units = 0;
    model_slot  = 0;
  endtask

  task automatic wait_pulses(input int n);
    int target;
    target = rises + n;
    while (rises < target) begin
      tick();
    end
  endtask

  // stop, then wait until no pulse shows for longer than a slot gap
  task automatic halt_scan();
    int rises_at_stop;
    int quiet;
    rises_at_stop = rises;
    send_cmd(cmd_stop);
    quiet = 0;
    while (quiet < 6) begin
      tick();
      quiet = output_sample ? 0 : quiet + 1;
    end
    check_value("pulses_after_stop_le_1", (rises - rises_at_stop) <= 1, 1);
  endtask

  task automatic drain_fifo();
    reads_on = 1'b1;
    while (model_q.size() != 0 || !sample_fifo_empty) begin
      tick();
    end
    reads_on = 1'b0;
    tick();
    check_value("sample_fifo_empty", sample_fifo_empty, 1);
  endtask

  // reference model, sampled mid-cycle where outputs are settled
  initial begin : model_monitor
    int          q_size;
    sample_rec_t rec;
    forever begin
      @(negedge clk);
      if (rst !== 1'b0) begin
        prev_sample = 1'b0;
        judge_due   = 1'b0;
      end else begin
        q_size = model_q.size();
        check_value("sample_fifo_empty", sample_fifo_empty, q_size == 0);
        check_value("sample_fifo_full", sample_fifo_full, q_size == fifo_depth);
        check_value("sample_fifo_almost_empty", sample_fifo_almost_empty,
                    q_size < fifo_almost);
        check_value("sample_fifo_almost_full", sample_fifo_almost_full,
                    (fifo_depth - q_size) < fifo_almost);
        if (sample_fifo_rd_en && q_size > 0) begin  // head leaves at the next edge
          check_value("sample_data_out", sample_data_out, model_q[0]);
          void'(model_q.pop_front());
        end
        if (judge_due) begin  // increment cycle, full test uses the count before it
          judge_due = 1'b0;
          if (cap_word != model_hist[cap_slot] && q_size < fifo_depth) begin
            rec.slot  = slot_idx_t'(cap_slot);
            rec.value = cap_word[rec_value_w-1:0];
            model_q.push_back(rec);
            model_hist[cap_slot] = cap_word;
          end
          model_slot = (model_slot == model_units - 1) ? 0 : model_slot + 1;
        end
        if (output_sample && !prev_sample) begin
          rises++;
          check_value("channel_select", channel_select, model_table[model_slot]);
          sample_due = 1'b1;
        end
        if (!output_sample && prev_sample) begin  // store cycle
          cap_word  = sample_data;
          cap_slot  = model_slot;
          judge_due = 1'b1;
        end
        prev_sample = output_sample;
      end
    end
  end

  initial begin : main_sequence
    int          n;
    logic [31:0] r;
    lfsr_state        = 16'd85;
    rst               = 1'b1;
    bus               = '0;
    bus_next          = '0;
    sample_data       = '0;
    sample_fifo_rd_en = 1'b0;
    reads_on          = 1'b0;
    sample_due        = 1'b0;
    rises             = 0;
    clear_model();
    repeat (10) tick();
    rst = 1'b0;
    tick();

    check_value("sample_fifo_empty", sample_fifo_empty, 1);
    check_value("sample_fifo_almost_full", sample_fifo_almost_full, 0);
    check_value("output_sample", output_sample, 0);
    send_cmd(cmd_start);  // empty table, nothing to scan
    repeat (12) tick();
    check_value("pulses_without_units", rises, 0);

    r = rand_bits(3);
    n = int'(r[2:0]) + 1;
    for (int i = 0; i < n; i++) begin
      add_unit(unit_pos_t'(rand_bits(8)));
    end
    write_reg({8'd241, addr_new_unit}, 32'h0000_0011);  // other block's address
    reads_on = 1'b1;
    send_cmd(cmd_start);
    wait_pulses(6 * n + 4);
    halt_scan();
    drain_fifo();

    send_cmd(cmd_reset);
    repeat (3) tick();
    clear_model();
    check_value("channel_select", channel_select, no_unit);
    sample_data = '0;  // repeats of zero must not be written after the clear
    for (int i = 0; i < max_units + 1; i++) begin
      add_unit(unit_pos_t'(rand_bits(8)));  // last one is past the table
    end
    reads_on = 1'b1;
    send_cmd(cmd_start);
    wait_pulses(max_units + 3);
    halt_scan();
    check_value("output_sample", output_sample, 0);

    reads_on = 1'b1;
    send_cmd(cmd_start);  // resumes at slot 0
    wait_pulses(3 * max_units);
    halt_scan();
    drain_fifo();

    reads_on = 1'b0;
    send_cmd(cmd_start);
    while (!sample_fifo_full) begin
      tick();
    end
    wait_pulses(2 * max_units + 2);  // these records meet a full FIFO
    halt_scan();
    check_value("model_records", model_q.size(), fifo_depth);
    drain_fifo();

    $display("Everything OK");
    $finish;
  end

endmodule

/* sources.f */
hdl/bus_pkg.sv
hdl/sample_pkg.sv
hdl/cmd_regs.sv
hdl/scan_sequencer.sv
hdl/change_filter.sv
hdl/sample_fifo.sv
hdl/sample_collector.sv
tests/sample_collector_properties.sv
tests/tb_sample_collector.sv

/* run_sim.sh */
#!/bin/sh
# build and run the sample collector testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_sample_collector -Mdir obj_dir -f sources.f
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/Vtb_sample_collector > sim.log 2>&1
status=$?
cat sim.log

if grep -q "Something failed" sim.log; then
  echo "simulation reported a failure"
  exit 1
fi
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi
echo "simulation passed"
exit 0
